// File: files.f
src/discrete_pkg.sv
src/audio_clk_en_gen.sv
src/square_wave_osc.sv
src/voice_mixer.sv
src/rc_lowpass.sv
src/sound_ctrl.sv
src/discrete_sound_top.sv
testbench/tb_discrete_sound.sv

// File: Makefile
# Verilator build and run for the discrete sound block.

VERILATOR ?= verilator
TOP       ?= tb_discrete_sound
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides, a fatal stop leaves no pass line in it.
run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_discrete_sound.sv
/*
 * testbench for the discrete sound block.
 * clock, reset, LFSR-timed host commands and a credit-feeding sink.
 * sample-level reference model of the voices, mixer and low-pass.
 * concurrent assertions on command credits, sample port and overrun.
 */
module tb_discrete_sound;

    timeunit 1ns;
    timeprecision 100ps;

    // samples per test phase.
    localparam int t2a = 14;
    localparam int t2b = 22;
    localparam int t3 = 17;
    localparam int t4 = 16;
    localparam int t5a = 20;
    localparam int t5b = 6;
    localparam int n_samples = t2a + t2b + t3 + t4 + t5a + t5b;
    localparam int step = int'(discrete_pkg::clk_en_step);
    localparam int modulus = int'(discrete_pkg::clk_en_mod);
    localparam int cycles_per_sample = (modulus + step - 1) / step;
    localparam int timeout_cycles = 4 * (n_samples * cycles_per_sample + 100);

    logic clk;
    logic arst_n;
    logic cmd_valid;
    discrete_pkg::cmd_op_e cmd_op;
    logic cmd_voice;
    logic [discrete_pkg::cmd_data_w-1:0] cmd_value;
    logic cmd_credit;
    logic sample_credit;
    logic sample_valid;
    logic signed [discrete_pkg::sample_w-1:0] sample_data;
    logic overrun;

    logic [31:0] lfsr;
    int          host_cred;
    int          cycles;
    int          sent_cnt;
    int          sat_hi;
    int          sat_lo;
    int          base;

    // settings as the host programmed them.
    logic cfg_en [2];
    int   cfg_per [2];
    int   cfg_gain [2];
    int   cfg_shift;

    // model state.
    int   osc_cnt [2];
    logic osc_lvl [2];
    int   m_filt;
    int   m_acc;
    logic m_clk_en;
    logic m_d1;
    logic m_d2;
    logic m_slot;
    int   m_exp;
    int   m_cred;
    logic m_overrun;
    int   m_init;
    logic m_cmd_d;
    logic m_send;
    logic exp_cmd_credit;

    discrete_sound_top u_discrete_sound_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_voice     (cmd_voice),
        .cmd_value     (cmd_value),
        .cmd_credit    (cmd_credit),
        .sample_credit (sample_credit),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .overrun       (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input int got, input int exp);
        $display("ERR %s got %h exp %h", name, got, exp);
        abort_run();
    endtask

    // galois LFSR, one step per bit handed out.
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // one voice tick, level held for period ticks then inverted.
    function automatic int osc_tick(input int v);
        int out;
        if (!cfg_en[v]) begin
            osc_cnt[v] = 0;
            osc_lvl[v] = 1'b1;
            return 0;
        end
        out = osc_lvl[v] ? int'(discrete_pkg::amp) : -int'(discrete_pkg::amp);
        if (osc_cnt[v] + 1 >= cfg_per[v]) begin
            osc_cnt[v] = 0;
            osc_lvl[v] = !osc_lvl[v];
        end else begin
            osc_cnt[v] = osc_cnt[v] + 1;
        end
        return out;
    endfunction

    // gain/8 per voice, clamp, then one-pole step.
    function automatic int model_sample();
        int mix;
        mix = (osc_tick(0) * cfg_gain[0]) >>> 3;
        mix = mix + ((osc_tick(1) * cfg_gain[1]) >>> 3);
        if (mix > int'(discrete_pkg::sample_max)) begin
            mix = int'(discrete_pkg::sample_max);
        end else if (mix < int'(discrete_pkg::sample_min)) begin
            mix = int'(discrete_pkg::sample_min);
        end
        if (cfg_shift == 0) begin
            m_filt = mix;
        end else begin
            m_filt = m_filt + ((mix - m_filt) >>> cfg_shift);
        end
        return m_filt;
    endfunction

    assign m_send         = m_slot && (m_cred != 0);
    assign exp_cmd_credit = (m_init != 0) || m_cmd_d;

    always @(posedge clk or negedge arst_n) begin
        int cred_n;
        if (!arst_n) begin
            m_acc      <= 0;
            m_clk_en   <= 1'b0;
            m_d1       <= 1'b0;
            m_d2       <= 1'b0;
            m_slot     <= 1'b0;
            m_exp      <= 0;
            m_cred     <= 0;
            m_overrun  <= 1'b0;
            m_init     <= discrete_pkg::cmd_depth;
            m_cmd_d    <= 1'b0;
            host_cred  <= 0;
            m_filt     = 0;
            osc_cnt[0] = 0;
            osc_cnt[1] = 0;
            osc_lvl[0] = 1'b1;
            osc_lvl[1] = 1'b1;
        end else begin
            // sample tick on each wrap of the rate accumulator.
            if (m_acc + step >= modulus) begin
                m_acc    <= m_acc + step - modulus;
                m_clk_en <= 1'b1;
            end else begin
                m_acc    <= m_acc + step;
                m_clk_en <= 1'b0;
            end
            // sample reaches the port 3 cycles after the tick.
            m_d1   <= m_clk_en;
            m_d2   <= m_d1;
            m_slot <= m_d2;
            if (m_d2) begin
                m_exp <= model_sample();
            end
            // a send and a credit in one cycle cancel.
            cred_n = m_cred;
            if (m_send) begin
                cred_n = cred_n - 1;
            end
            if (sample_credit && (cred_n < int'(discrete_pkg::credit_max))) begin
                cred_n = cred_n + 1;
            end
            m_cred <= cred_n;
            if (m_slot && (m_cred == 0)) begin
                m_overrun <= 1'b1;
            end
            // initial credit burst, then one credit the cycle after each command.
            m_init    <= (m_init != 0) ? m_init - 1 : 0;
            m_cmd_d   <= cmd_valid;
            host_cred <= host_cred + int'(cmd_credit) - int'(cmd_valid);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (arst_n && sample_valid) begin
            sent_cnt <= sent_cnt + 1;
            if (sample_data == discrete_pkg::sample_max) begin
                sat_hi <= sat_hi + 1;
            end
            if (sample_data == discrete_pkg::sample_min) begin
                sat_lo <= sat_lo + 1;
            end
        end
        if (cycles == timeout_cycles) begin
            $display("timeout, run did not finish within %0d cycles", timeout_cycles);
            abort_run();
        end
    end

    a_cmd_credit: assert property (@(posedge clk) disable iff (!arst_n)
        cmd_credit == exp_cmd_credit)
        else value_error("cmd_credit", int'($sampled(cmd_credit)),
                         int'($sampled(exp_cmd_credit)));

    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        host_cred <= discrete_pkg::cmd_depth)
        else value_error("host_cred", $sampled(host_cred), discrete_pkg::cmd_depth);

    a_sample_valid: assert property (@(posedge clk) disable iff (!arst_n)
        sample_valid == m_send)
        else value_error("sample_valid", int'($sampled(sample_valid)), int'($sampled(m_send)));

    a_sample_data: assert property (@(posedge clk) disable iff (!arst_n)
        sample_valid |-> (int'(sample_data) == m_exp))
        else value_error("sample_data", int'($sampled(sample_data)), $sampled(m_exp));

    a_overrun: assert property (@(posedge clk) disable iff (!arst_n)
        overrun == m_overrun)
        else value_error("overrun", int'($sampled(overrun)), int'($sampled(m_overrun)));

    // commands land in the gap after a sample slot, well before the next tick.
    task automatic send_cmd(input discrete_pkg::cmd_op_e op, input logic voice,
                            input logic [discrete_pkg::cmd_data_w-1:0] value);
        int gap;
        gap = take_bits(3);
        repeat (gap) begin
            @(posedge clk);
            #10;
        end
        while (host_cred == 0) begin
            @(posedge clk);
            #10;
        end
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_voice = voice;
        cmd_value = value;
        @(posedge clk);
        #10;
        cmd_valid = 1'b0;
        cmd_op    = discrete_pkg::op_nop;
        case (op)
            discrete_pkg::op_set_period: cfg_per[voice] = int'(value);
            discrete_pkg::op_set_gain:   cfg_gain[voice] = int'(value[discrete_pkg::gain_w-1:0]);
            discrete_pkg::op_set_enable: cfg_en[voice] = value[0];
            discrete_pkg::op_set_filter: cfg_shift = int'(value[discrete_pkg::shift_w-1:0]);
            default: begin
            end
        endcase
    endtask

    // wait for the next sample slot, feed one sink credit if asked.
    task automatic next_sample(input logic feed);
        do begin
            @(posedge clk);
            #10;
        end while (!m_slot);
        sample_credit = feed;
        @(posedge clk);
        #10;
        sample_credit = 1'b0;
    endtask

    task automatic run_samples(input int n, input logic feed);
        repeat (n) next_sample(feed);
    endtask

    task automatic give_credits(input int n);
        repeat (n) begin
            sample_credit = 1'b1;
            @(posedge clk);
            #10;
        end
        sample_credit = 1'b0;
    endtask

    initial begin
        lfsr          = 32'h1cdb;
        arst_n        = 1'b0;
        cmd_valid     = 1'b0;
        cmd_op        = discrete_pkg::op_nop;
        cmd_voice     = 1'b0;
        cmd_value     = '0;
        sample_credit = 1'b0;
        cfg_en[0]     = 1'b0;
        cfg_en[1]     = 1'b0;
        cfg_per[0]    = 1;
        cfg_per[1]    = 1;
        cfg_gain[0]   = 8;
        cfg_gain[1]   = 8;
        cfg_shift     = 0;
        repeat (2) @(posedge clk);
        #10;
        arst_n = 1'b1;
        repeat (8) begin
            @(posedge clk);
            #10;
        end
        if (host_cred != discrete_pkg::cmd_depth) begin
            value_error("cmd_credit count", host_cred, discrete_pkg::cmd_depth);
        end
        give_credits(15);

        // one voice at unity, two periods.
        send_cmd(discrete_pkg::op_set_period, 1'b0, 16'd3);
        send_cmd(discrete_pkg::op_set_enable, 1'b0, 16'd1);
        run_samples(t2a, 1'b1);
        send_cmd(discrete_pkg::op_set_period, 1'b0, 16'd5);
        run_samples(t2b, 1'b1);

        // both voices in phase at gain 15, then silence.
        send_cmd(discrete_pkg::op_set_enable, 1'b0, 16'd0);
        send_cmd(discrete_pkg::op_set_gain, 1'b0, 16'd15);
        send_cmd(discrete_pkg::op_set_gain, 1'b1, 16'd15);
        send_cmd(discrete_pkg::op_set_period, 1'b1, 16'd5);
        run_samples(1, 1'b1);
        send_cmd(discrete_pkg::op_set_enable, 1'b0, 16'd1);
        send_cmd(discrete_pkg::op_set_enable, 1'b1, 16'd1);
        run_samples(12, 1'b1);
        send_cmd(discrete_pkg::op_set_enable, 1'b0, 16'd0);
        send_cmd(discrete_pkg::op_set_enable, 1'b1, 16'd0);
        run_samples(t3 - 13, 1'b1);

        // low-pass with shift 2 on a single voice.
        send_cmd(discrete_pkg::op_set_gain, 1'b0, 16'd8);
        send_cmd(discrete_pkg::op_set_period, 1'b0, 16'd4);
        send_cmd(discrete_pkg::op_set_filter, 1'b0, 16'd2);
        send_cmd(discrete_pkg::op_set_enable, 1'b0, 16'd1);
        run_samples(t4, 1'b1);

        // sink stops, the credit stock runs out and samples drop.
        run_samples(t5a, 1'b0);
        base = sent_cnt;
        give_credits(3);
        run_samples(t5b, 1'b0);
        if (sent_cnt - base != 3) begin
            value_error("sample_valid count", sent_cnt - base, 3);
        end

        if ((sat_hi == 0) || (sat_lo == 0)) begin
            $display("sample_data never reached both saturation limits");
            abort_run();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: src/discrete_sound_top.sv
/*
 * top level of the discrete sound block.
 * sample enable, two square voices, mixer, low-pass and control.
 */
module discrete_sound_top (
    input  logic clk,
    input  logic arst_n,
    input  logic cmd_valid,
    input  discrete_pkg::cmd_op_e cmd_op,
    input  logic cmd_voice,
    input  logic [discrete_pkg::cmd_data_w-1:0] cmd_value,
    output logic cmd_credit,
    input  logic sample_credit,
    output logic sample_valid,
    output logic signed [discrete_pkg::sample_w-1:0] sample_data,
    output logic overrun
);

    logic                                     clk_en;
    logic                                     enable_a;
    logic                                     enable_b;
    logic [discrete_pkg::period_w-1:0]        period_a;
    logic [discrete_pkg::period_w-1:0]        period_b;
    logic [discrete_pkg::gain_w-1:0]          gain_a;
    logic [discrete_pkg::gain_w-1:0]          gain_b;
    logic [discrete_pkg::shift_w-1:0]         filter_shift;
    logic signed [discrete_pkg::sample_w-1:0] voice_a;
    logic signed [discrete_pkg::sample_w-1:0] voice_b;
    logic signed [discrete_pkg::sample_w-1:0] mix_out;
    logic                                     mix_valid;
    logic signed [discrete_pkg::sample_w-1:0] filt_sample;
    logic                                     filt_valid;

    audio_clk_en_gen u_audio_clk_en_gen (
        .clk    (clk),
        .arst_n (arst_n),
        .clk_en (clk_en)
    );

    // voices advance on clk_en.
    square_wave_osc u_osc_a (
        .clk       (clk),
        .arst_n    (arst_n),
        .clk_en    (clk_en),
        .enable    (enable_a),
        .period    (period_a),
        .voice_out (voice_a)
    );

    square_wave_osc u_osc_b (
        .clk       (clk),
        .arst_n    (arst_n),
        .clk_en    (clk_en),
        .enable    (enable_b),
        .period    (period_b),
        .voice_out (voice_b)
    );

    // mix is valid 2 cycles after clk_en.
    voice_mixer u_voice_mixer (
        .clk       (clk),
        .arst_n    (arst_n),
        .clk_en    (clk_en),
        .voice_a   (voice_a),
        .voice_b   (voice_b),
        .gain_a    (gain_a),
        .gain_b    (gain_b),
        .mix_out   (mix_out),
        .mix_valid (mix_valid)
    );

    // filtered sample is valid 3 cycles after clk_en.
    rc_lowpass u_rc_lowpass (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (mix_valid),
        .in_sample  (mix_out),
        .shift      (filter_shift),
        .out_valid  (filt_valid),
        .out_sample (filt_sample)
    );

    sound_ctrl u_sound_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_voice     (cmd_voice),
        .cmd_value     (cmd_value),
        .cmd_credit    (cmd_credit),
        .enable_a      (enable_a),
        .enable_b      (enable_b),
        .period_a      (period_a),
        .period_b      (period_b),
        .gain_a        (gain_a),
        .gain_b        (gain_b),
        .filter_shift  (filter_shift),
        .filt_valid    (filt_valid),
        .filt_sample   (filt_sample),
        .sample_credit (sample_credit),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .overrun       (overrun)
    );

endmodule

// File: src/sound_ctrl.sv
/*
 * control block of the sound unit.
 * command FIFO, opcode decode into voice and filter registers.
 * command credit return, with the burst after reset.
 * sample credit counter, send or drop, sticky overrun.
 */
module sound_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic cmd_valid,
    input  discrete_pkg::cmd_op_e cmd_op,
    input  logic cmd_voice,
    input  logic [discrete_pkg::cmd_data_w-1:0] cmd_value,
    output logic cmd_credit,
    output logic enable_a,
    output logic enable_b,
    output logic [discrete_pkg::period_w-1:0] period_a,
    output logic [discrete_pkg::period_w-1:0] period_b,
    output logic [discrete_pkg::gain_w-1:0] gain_a,
    output logic [discrete_pkg::gain_w-1:0] gain_b,
    output logic [discrete_pkg::shift_w-1:0] filter_shift,
    input  logic filt_valid,
    input  logic signed [discrete_pkg::sample_w-1:0] filt_sample,
    input  logic sample_credit,
    output logic sample_valid,
    output logic signed [discrete_pkg::sample_w-1:0] sample_data,
    output logic overrun
);

    discrete_pkg::cmd_op_e                fifo_op    [discrete_pkg::cmd_depth];
    logic                                 fifo_voice [discrete_pkg::cmd_depth];
    logic [discrete_pkg::cmd_data_w-1:0]  fifo_value [discrete_pkg::cmd_depth];
    logic [discrete_pkg::cmd_ptr_w-1:0]   wr_ptr;
    logic [discrete_pkg::cmd_ptr_w-1:0]   rd_ptr;
    logic [discrete_pkg::cmd_cnt_w-1:0]   fifo_count;
    logic [discrete_pkg::cmd_cnt_w-1:0]   init_cnt;
    logic                                 rd_en;
    discrete_pkg::cmd_op_e                rd_op;
    logic                                 rd_voice;
    logic [discrete_pkg::cmd_data_w-1:0]  rd_value;
    logic [discrete_pkg::credit_w-1:0]    credit_cnt;
    logic                                 send;

    // decode waits for the reset credit burst, one credit pulse per cycle.
    assign rd_en      = (init_cnt == '0) && (fifo_count != '0);
    assign cmd_credit = (init_cnt != '0) || rd_en;

    assign rd_op    = fifo_op[rd_ptr];
    assign rd_voice = fifo_voice[rd_ptr];
    assign rd_value = fifo_value[rd_ptr];

    // every command is written, the host only sends with a credit.
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            fifo_op[wr_ptr]    <= cmd_op;
            fifo_voice[wr_ptr] <= cmd_voice;
            fifo_value[wr_ptr] <= cmd_value;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            init_cnt   <= discrete_pkg::cmd_slots;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({cmd_valid, rd_en})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
            if (init_cnt != '0) begin
                init_cnt <= init_cnt - 1'b1;
            end
        end
    end

    // register writes land the cycle after the FIFO read.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable_a     <= 1'b0;
            enable_b     <= 1'b0;
            period_a     <= discrete_pkg::period_init;
            period_b     <= discrete_pkg::period_init;
            gain_a       <= discrete_pkg::gain_unity;
            gain_b       <= discrete_pkg::gain_unity;
            filter_shift <= '0;
        end else if (rd_en) begin
            case (rd_op)
                discrete_pkg::op_set_period: begin
                    if (rd_voice) begin
                        period_b <= rd_value[discrete_pkg::period_w-1:0];
                    end else begin
                        period_a <= rd_value[discrete_pkg::period_w-1:0];
                    end
                end
                discrete_pkg::op_set_gain: begin
                    if (rd_voice) begin
                        gain_b <= rd_value[discrete_pkg::gain_w-1:0];
                    end else begin
                        gain_a <= rd_value[discrete_pkg::gain_w-1:0];
                    end
                end
                discrete_pkg::op_set_enable: begin
                    if (rd_voice) begin
                        enable_b <= rd_value[0];
                    end else begin
                        enable_a <= rd_value[0];
                    end
                end
                discrete_pkg::op_set_filter: begin
                    filter_shift <= rd_value[discrete_pkg::shift_w-1:0];
                end
                // nop and unknown codes still free their slot.
                default: begin
                end
            endcase
        end
    end

    // a sample goes out only with a credit in hand.
    assign send         = filt_valid && (credit_cnt != '0);
    assign sample_valid = send;
    assign sample_data  = filt_sample;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= '0;
            overrun    <= 1'b0;
        end else begin
            // credit and send in one cycle cancel out.
            if (sample_credit && !send && (credit_cnt != discrete_pkg::credit_max)) begin
                credit_cnt <= credit_cnt + 1'b1;
            end else if (send && !sample_credit) begin
                credit_cnt <= credit_cnt - 1'b1;
            end
            // dropped sample, stays set until reset.
            if (filt_valid && (credit_cnt == '0)) begin
                overrun <= 1'b1;
            end
        end
    end

    // host must hold a credit, so a full FIFO never sees a command.
    a_cmd_not_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        cmd_valid |-> (fifo_count != discrete_pkg::cmd_slots)
    );

    // counter saturates at both ends.
    a_credit_no_underflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        (credit_cnt == '0) |=> (credit_cnt != discrete_pkg::credit_max)
    );

    a_credit_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        (credit_cnt == discrete_pkg::credit_max) |=> (credit_cnt != '0)
    );

endmodule

// File: src/rc_lowpass.sv
/*
 * one-pole low-pass.
 * state moves toward the input by the difference shifted right by shift.
 * shift 0 passes the input straight through.
 */
module rc_lowpass (
    input  logic clk,
    input  logic arst_n,
    input  logic in_valid,
    input  logic signed [discrete_pkg::sample_w-1:0] in_sample,
    input  logic [discrete_pkg::shift_w-1:0] shift,
    output logic out_valid,
    output logic signed [discrete_pkg::sample_w-1:0] out_sample
);

    // one extra bit, the difference of two samples needs 17.
    logic signed [discrete_pkg::sample_w:0] diff;
    logic signed [discrete_pkg::sample_w:0] step;
    logic signed [discrete_pkg::sample_w:0] next_state;

    assign diff       = in_sample - out_sample;
    assign step       = diff >>> shift;
    // stays between old state and input, so it fits 16 bits.
    assign next_state = out_sample + step;

    // out_sample is the filter state itself.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            out_sample <= '0;
        end else begin
            out_valid <= in_valid;
            // shift 0 adds the whole difference, so the state lands on the input.
            if (in_valid) begin
                out_sample <= next_state[discrete_pkg::sample_w-1:0];
            end
        end
    end

endmodule

// File: src/voice_mixer.sv
/*
 * two-voice mixer.
 * scales each voice by gain/8, sums, saturates to 16 bits.
 * output registered one cycle after the oscillators update.
 */
module voice_mixer (
    input  logic clk,
    input  logic arst_n,
    input  logic clk_en,
    input  logic signed [discrete_pkg::sample_w-1:0] voice_a,
    input  logic signed [discrete_pkg::sample_w-1:0] voice_b,
    input  logic [discrete_pkg::gain_w-1:0] gain_a,
    input  logic [discrete_pkg::gain_w-1:0] gain_b,
    output logic signed [discrete_pkg::sample_w-1:0] mix_out,
    output logic mix_valid
);

    logic                                   en_d;
    logic signed [discrete_pkg::prod_w-1:0]   prod_a;
    logic signed [discrete_pkg::prod_w-1:0]   prod_b;
    logic signed [discrete_pkg::sum_w-1:0]    sum;
    logic signed [discrete_pkg::sample_w-1:0] sat;

    // gain is unsigned, a zero msb keeps the product signed.
    assign prod_a = voice_a * $signed({1'b0, gain_a});
    assign prod_b = voice_b * $signed({1'b0, gain_b});

    // drop the 3 fraction bits of the gain.
    assign sum = (prod_a >>> discrete_pkg::gain_frac) + (prod_b >>> discrete_pkg::gain_frac);

    always_comb begin
        if (sum > discrete_pkg::sample_max) begin
            sat = discrete_pkg::sample_max;
        end else if (sum < discrete_pkg::sample_min) begin
            sat = discrete_pkg::sample_min;
        end else begin
            sat = sum[discrete_pkg::sample_w-1:0];
        end
    end

    // voices are settled one cycle after clk_en.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            en_d      <= 1'b0;
            mix_valid <= 1'b0;
        end else begin
            en_d      <= clk_en;
            mix_valid <= en_d;
        end
    end

    always_ff @(posedge clk) begin
        if (en_d) begin
            mix_out <= sat;
        end
    end

endmodule

// File: src/square_wave_osc.sv
/*
 * square wave voice.
 * counts clk_en ticks up to a programmable half period, then toggles.
 * outputs +amp, -amp, or 0 while disabled.
 */
module square_wave_osc (
    input  logic clk,
    input  logic arst_n,
    input  logic clk_en,
    input  logic enable,
    input  logic [discrete_pkg::period_w-1:0] period,
    output logic signed [discrete_pkg::sample_w-1:0] voice_out
);

    logic [discrete_pkg::period_w-1:0] cnt;
    logic                              level;
    logic                              half_done;

    // last tick of the half period.
    // a period of 0 behaves like 1.
    assign half_done = ({1'b0, cnt} + 1'b1) >= {1'b0, period};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt       <= '0;
            level     <= 1'b1;
            voice_out <= '0;
        end else if (!enable) begin
            // silent, and ready to start high again.
            cnt       <= '0;
            level     <= 1'b1;
            voice_out <= '0;
        end else if (clk_en) begin
            voice_out <= level ? discrete_pkg::amp : -discrete_pkg::amp;
            if (half_done) begin
                cnt   <= '0;
                level <= ~level;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: src/audio_clk_en_gen.sv
/*
 * sample-rate enable generator.
 * fractional accumulator, one-cycle clk_en on each wrap.
 */
module audio_clk_en_gen (
    input  logic clk,
    input  logic arst_n,
    output logic clk_en
);

    logic [discrete_pkg::clk_en_acc_w-1:0] acc;
    logic [discrete_pkg::clk_en_acc_w:0]   acc_sum;

    // one spare bit so the sum cannot overflow before the compare.
    assign acc_sum = {1'b0, acc} + {1'b0, discrete_pkg::clk_en_step};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc    <= '0;
            clk_en <= 1'b0;
        end else if (acc_sum >= {1'b0, discrete_pkg::clk_en_mod}) begin
            // wrap keeps the remainder, so the average rate is exact.
            acc    <= acc_sum[discrete_pkg::clk_en_acc_w-1:0] - discrete_pkg::clk_en_mod;
            clk_en <= 1'b1;
        end else begin
            acc    <= acc_sum[discrete_pkg::clk_en_acc_w-1:0];
            clk_en <= 1'b0;
        end
    end

    // the pipeline behind this needs a gap between sample ticks.
    a_clk_en_single: assert property (
        @(posedge clk) disable iff (!arst_n) clk_en |=> !clk_en
    );

endmodule

// File: src/discrete_pkg.sv
/*
 * shared definitions for the discrete sound block.
 * sample, period, gain and filter widths.
 * command FIFO depth and sample credit limits.
 * sample-rate enable accumulator constants.
 * command opcode enum.
 */
package discrete_pkg;

    // audio samples are signed 16 bit.
    localparam int sample_w = 16;
    localparam logic signed [sample_w-1:0] sample_max = 16'sh7fff;
    localparam logic signed [sample_w-1:0] sample_min = -16'sh8000;

    // square wave level, each voice swings between +amp and -amp.
    localparam logic signed [sample_w-1:0] amp = 16'sd16383;

    // oscillator half period, counted in samples.
    localparam int period_w = 16;
    localparam logic [period_w-1:0] period_init = 16'd1;

    // voice gain is gain/8, so 8 is unity.
    localparam int gain_w = 4;
    localparam int gain_frac = 3;
    localparam logic [gain_w-1:0] gain_unity = 4'd8;

    // mixer widths: product of voice and unsigned gain, then the two-voice sum.
    localparam int prod_w = sample_w + gain_w + 1;
    localparam int sum_w = prod_w + 1;

    // low-pass shift, 0 is bypass.
    localparam int shift_w = 3;

    // command FIFO, depth equals the credits handed out after reset.
    localparam int cmd_depth = 4;
    localparam int cmd_ptr_w = $clog2(cmd_depth);
    localparam int cmd_cnt_w = cmd_ptr_w + 1;
    localparam logic [cmd_cnt_w-1:0] cmd_slots = cmd_cnt_w'(cmd_depth);
    localparam int cmd_data_w = 16;

    // sample credit counter saturates at its all-ones value.
    localparam int credit_w = 4;
    localparam logic [credit_w-1:0] credit_max = '1;

    // 48 kHz from 50 MHz is 3/3125.
    localparam int clk_en_acc_w = 12;
    localparam logic [clk_en_acc_w-1:0] clk_en_step = 12'd3;
    localparam logic [clk_en_acc_w-1:0] clk_en_mod = 12'd3125;

    // host command opcodes.
    typedef enum logic [2:0] {
        op_nop        = 3'd0,
        op_set_period = 3'd1,
        op_set_gain   = 3'd2,
        op_set_enable = 3'd3,
        op_set_filter = 3'd4
    } cmd_op_e;

endpackage
